// ==== Makefile ====
# Verilator build and run of the CPU interface control testbench

SIM       := verilator
SIM_FLAGS := --binary --timing
TOP       := cpu_if_tb
FILELIST  := cpu_if_top.f
OBJ_DIR   := obj_dir
PASS_TEXT := Simulation PASSED

SOURCES   := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass line shows up in the output
test: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/cpu_if_tb.sv ====
`timescale 1ns/1ns

// testbench for cpu_if_top
// a bus responder model answers each request after a random delay
// every row of the table says what the DUT must show for one operation
module cpu_if_tb;

	localparam int dly_ticks = cpu_if_pkg::default_alarm_dly_ticks;
	localparam int pulse_ticks = cpu_if_pkg::default_alarm_ticks;
	localparam int n_tests = 9;
	localparam int reset_cycles = 16;

	// each row gets a generous budget of alarm delay, alarm pulse and handshake cycles
	localparam int cycle_limit = n_tests * 4 * (dly_ticks + pulse_ticks + 20);

	logic clk;
	logic reset;
	logic start;
	logic skip_write;
	logic ren;
	logic rok;
	cpu_if_pkg::access_op_t op;
	logic zg;
	logic zwzg;
	logic ok;
	logic talarm;
	logic busy;
	logic done;
	logic write_phase;
	cpu_if_pkg::seq_state_t state;

	// stimulus table, one entry per index
	// exp_wp holds write_phase as seen at each ok pulse, bit 0 for the first access
	string t_name [n_tests];
	cpu_if_pkg::access_op_t t_op [n_tests];
	bit t_skip [n_tests];
	int t_width [n_tests];
	bit t_use_ren [n_tests];
	bit t_silent [n_tests];
	bit t_restart [n_tests];
	int t_exp_ok [n_tests];
	bit t_exp_hold [n_tests];
	bit t_exp_alarm [n_tests];
	int t_exp_wp [n_tests];

	int n_rows = 0;
	int cycle_count = 0;
	int test_errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	logic [31:0] rnd = 32'h865710f0;

	cpu_if_top u_cpu_if_top (
		.__clk(clk),
		.reset(reset),
		.start(start),
		.skip_write(skip_write),
		.ren(ren),
		.rok(rok),
		.op(op),
		.zg(zg),
		.zwzg(zwzg),
		.ok(ok),
		.talarm(talarm),
		.busy(busy),
		.done(done),
		.write_phase(write_phase),
		.state(state)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// the run is cut off if the table takes far longer than it should
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: the tests did not finish within %0d cycles", cycle_limit);
			$display("Simulation FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic add_row(input string name, input cpu_if_pkg::access_op_t o, input bit skip,
		input int width, input bit use_ren, input bit silent, input bit restart,
		input int exp_ok, input bit exp_hold, input bit exp_alarm, input int exp_wp);
		t_name[n_rows] = name;
		t_op[n_rows] = o;
		t_skip[n_rows] = skip;
		t_width[n_rows] = width;
		t_use_ren[n_rows] = use_ren;
		t_silent[n_rows] = silent;
		t_restart[n_rows] = restart;
		t_exp_ok[n_rows] = exp_ok;
		t_exp_hold[n_rows] = exp_hold;
		t_exp_alarm[n_rows] = exp_alarm;
		t_exp_wp[n_rows] = exp_wp;
		n_rows++;
	endtask

	// widths stay at 3 or less so that delay plus width never reaches the alarm
	task automatic fill_table();
		add_row("read_rok", cpu_if_pkg::op_read, 0, 2, 0, 0, 0, 1, 0, 0, 0);
		add_row("write_rok", cpu_if_pkg::op_write, 0, 1, 0, 0, 0, 1, 0, 0, 1);
		add_row("read_ren", cpu_if_pkg::op_read, 0, 3, 1, 0, 0, 1, 0, 0, 0);
		add_row("write_ren", cpu_if_pkg::op_write, 0, 2, 1, 0, 0, 1, 0, 0, 1);
		add_row("rmw", cpu_if_pkg::op_rmw, 0, 2, 0, 0, 0, 2, 1, 0, 2);
		add_row("cond_rmw_skip", cpu_if_pkg::op_cond_rmw, 1, 2, 0, 0, 0, 1, 0, 0, 0);
		add_row("cond_rmw_write", cpu_if_pkg::op_cond_rmw, 0, 3, 1, 0, 0, 2, 1, 0, 2);
		// nobody answers, so the alarm has to end the access
		add_row("no_answer", cpu_if_pkg::op_read, 0, 0, 0, 1, 0, 1, 0, 1, 0);
		add_row("start_while_busy", cpu_if_pkg::op_read, 0, 2, 0, 0, 1, 1, 0, 0, 0);
	endtask

	task automatic report_mismatch(input string name, input string what,
		input logic signed [31:0] expected, input logic signed [31:0] actual);
		$display("ERROR %s: %s expected %0d actual %0d", name, what, expected, actual);
		test_errors++;
	endtask

	task automatic report_test(input string name);
		if (test_errors == 0) begin
			$display("test %s: pass", name);
			tests_passed++;
		end else begin
			$display("test %s: fail with %0d errors", name, test_errors);
			tests_failed++;
		end
	endtask

	task automatic check_idle(input string where);
		if ({zg, zwzg, ok, talarm, done, busy, write_phase} !== 7'b0) begin
			$display("ERROR reset_state: outputs %s expected 0000000 actual %b", where,
				{zg, zwzg, ok, talarm, done, busy, write_phase});
			test_errors++;
		end
		if (state !== cpu_if_pkg::st_idle) begin
			$display("ERROR reset_state: state %s expected %0d actual %0d", where,
				cpu_if_pkg::st_idle, state);
			test_errors++;
		end
	endtask

	task automatic run_reset();
		test_errors = 0;
		reset = 1'b1;
		repeat (reset_cycles) begin
			@(negedge clk);
			check_idle("during reset");
		end
		reset = 1'b0;
		@(negedge clk);
		check_idle("after reset");
		report_test("reset_state");
	endtask

	// one operation from the start pulse to done, sampled once per cycle at the falling edge
	task automatic run_row(input int i);
		int cyc;
		int ok_cnt;
		int wp_bits;
		int zwzg_rise_cyc;
		int alarm_rise_cyc;
		int alarm_fall_cyc;
		int alarm_len;
		int alarm_rises;
		int ok_rise_cyc;
		int zg_gaps;
		int zwzg_drops;
		int rsp_left;
		int rsp_hold;
		bit rsp_pending;
		bit in_access;
		bit track_hold;
		bit first_rise;
		bit done_seen;
		logic prev_zwzg;
		logic prev_ok;
		logic prev_talarm;
		test_errors = 0;
		cyc = 0;
		ok_cnt = 0;
		wp_bits = 0;
		zwzg_rise_cyc = 0;
		alarm_rise_cyc = 0;
		alarm_fall_cyc = 0;
		alarm_len = 0;
		alarm_rises = 0;
		ok_rise_cyc = 0;
		zg_gaps = 0;
		zwzg_drops = 0;
		rsp_left = 0;
		rsp_hold = 0;
		rsp_pending = 1'b0;
		in_access = 1'b0;
		track_hold = 1'b0;
		first_rise = 1'b0;
		done_seen = 1'b0;
		prev_zwzg = 1'b0;
		prev_ok = 1'b0;
		prev_talarm = 1'b0;
		@(negedge clk);
		op = t_op[i];
		skip_write = t_skip[i];
		start = 1'b1;
		@(negedge clk);
		while (!done_seen) begin
			start = 1'b0;
			// a new request from the interface arms the responder
			if (zwzg && !prev_zwzg) begin
				in_access = 1'b1;
				if (!first_rise) begin
					first_rise = 1'b1;
					track_hold = 1'b1;
					zwzg_rise_cyc = cyc;
					// the sequencer is busy now and must ignore this
					if (t_restart[i])
						start = 1'b1;
				end
				if (!t_silent[i]) begin
					rnd = xorshift32(rnd);
					rsp_left = int'(rnd % 32'd4);
					rsp_pending = 1'b1;
				end
			end
			if (track_hold && !zg)
				zg_gaps++;
			if (in_access && !zwzg)
				zwzg_drops++;
			if ((ren || rok) && !zwzg)
				zwzg_drops++;
			if (talarm && !prev_talarm) begin
				alarm_rises++;
				alarm_rise_cyc = cyc;
			end
			if (talarm)
				alarm_len++;
			if (!talarm && prev_talarm)
				alarm_fall_cyc = cyc;
			if (ok && !prev_ok) begin
				if (write_phase)
					wp_bits = wp_bits | (1 << ok_cnt);
				ok_cnt++;
				ok_rise_cyc = cyc;
				in_access = 1'b0;
				if (ok_cnt >= t_exp_ok[i])
					track_hold = 1'b0;
			end
			if (done)
				done_seen = 1'b1;
			prev_zwzg = zwzg;
			prev_ok = ok;
			prev_talarm = talarm;
			// responder model, it waits out the delay and then holds its answer for width cycles
			if (rsp_pending) begin
				if (rsp_left == 0) begin
					rsp_pending = 1'b0;
					rsp_hold = t_width[i];
				end else begin
					rsp_left--;
				end
			end
			ren = 1'b0;
			rok = 1'b0;
			if (rsp_hold > 0) begin
				if (t_use_ren[i])
					ren = 1'b1;
				else
					rok = 1'b1;
				rsp_hold--;
			end
			if (!done_seen) begin
				@(negedge clk);
				cyc++;
			end
		end
		if (ok_cnt != t_exp_ok[i])
			report_mismatch(t_name[i], "ok pulses", t_exp_ok[i], ok_cnt);
		if (wp_bits != t_exp_wp[i])
			report_mismatch(t_name[i], "write_phase at each ok", t_exp_wp[i], wp_bits);
		if (zwzg_drops != 0)
			report_mismatch(t_name[i], "cycles with zwzg low in an access", 0, zwzg_drops);
		if (t_exp_hold[i] && (zg_gaps != 0))
			report_mismatch(t_name[i], "zg low cycles inside the pair", 0, zg_gaps);
		if (t_exp_alarm[i]) begin
			if (alarm_rises != 1)
				report_mismatch(t_name[i], "talarm pulses", 1, alarm_rises);
			if ((alarm_rise_cyc - zwzg_rise_cyc) != (dly_ticks + 1))
				report_mismatch(t_name[i], "talarm delay after zwzg", dly_ticks + 1,
					alarm_rise_cyc - zwzg_rise_cyc);
			if (alarm_len != pulse_ticks)
				report_mismatch(t_name[i], "talarm width", pulse_ticks, alarm_len);
			if ((ok_rise_cyc - alarm_fall_cyc) != 1)
				report_mismatch(t_name[i], "ok delay after talarm falls", 1,
					ok_rise_cyc - alarm_fall_cyc);
		end else if (alarm_rises != 0) begin
			report_mismatch(t_name[i], "talarm pulses", 0, alarm_rises);
		end
		// one cycle after done the bus must be free and the sequencer idle
		@(negedge clk);
		if (zg !== 1'b0)
			report_mismatch(t_name[i], "zg after done", 0, 32'(zg));
		if (busy !== 1'b0)
			report_mismatch(t_name[i], "busy after done", 0, 32'(busy));
		if (state !== cpu_if_pkg::st_idle)
			report_mismatch(t_name[i], "state after done", 32'(cpu_if_pkg::st_idle), 32'(state));
		report_test(t_name[i]);
	endtask

	initial begin
		reset = 1'b1;
		start = 1'b0;
		skip_write = 1'b0;
		ren = 1'b0;
		rok = 1'b0;
		op = cpu_if_pkg::op_read;
		fill_table();
		run_reset();
		for (int i = 0; i < n_rows; i++)
			run_row(i);
		$display("tests run %0d, passed %0d, failed %0d", tests_passed + tests_failed,
			tests_passed, tests_failed);
		if (tests_failed == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== cpu_if_top.f ====
rtl/cpu_if_pkg.sv
rtl/alarm_timer.sv
rtl/ifctl.sv
rtl/if_sequencer.sv
rtl/cpu_if_top.sv
bench/cpu_if_tb.sv

// ==== rtl/alarm_timer.sv ====
`timescale 1ns/1ns

// delay followed by a one-shot
// once trigger has been high for dly_ticks cycles a pulse of pulse_ticks cycles follows
module alarm_timer #(
	parameter int dly_ticks = cpu_if_pkg::default_alarm_dly_ticks,
	parameter int pulse_ticks = cpu_if_pkg::default_alarm_ticks
) (
	input logic __clk,
	input logic reset,
	input logic trigger,
	output logic pulse
);

	localparam int dly_w = $clog2(dly_ticks + 1);
	localparam int pulse_w = $clog2(pulse_ticks + 1);

	logic [dly_w-1:0] dly_cnt;
	logic [pulse_w-1:0] pulse_cnt;

	// the timer has fired for this trigger level
	logic fired;

	// delay part
	// counts while trigger stays high and starts over as soon as it drops
	always_ff @(posedge __clk) begin
		if (reset) begin
			dly_cnt <= '0;
			fired <= 1'b0;
		end else if (!trigger) begin
			dly_cnt <= '0;
			fired <= 1'b0;
		end else if (!fired) begin
			if (dly_cnt == dly_w'(dly_ticks))
				fired <= 1'b1;
			else
				dly_cnt <= dly_cnt + 1'b1;
		end
	end

	// one-shot part
	// it is loaded in the same cycle the delay runs out and then counts down to zero
	// the pulse keeps its width even if trigger drops in the middle
	always_ff @(posedge __clk) begin
		if (reset)
			pulse_cnt <= '0;
		else if (trigger && !fired && (dly_cnt == dly_w'(dly_ticks)))
			pulse_cnt <= pulse_w'(pulse_ticks);
		else if (pulse_cnt != '0)
			pulse_cnt <= pulse_cnt - 1'b1;
	end

	assign pulse = (pulse_cnt != '0);

endmodule

// ==== rtl/cpu_if_pkg.sv ====
package cpu_if_pkg;

	// kind of memory access the CPU asks the interface for
	// the two rmw kinds keep the bus claimed between their read and their write
	typedef enum logic [1:0] {
		op_read = 2'd0,
		op_write = 2'd1,
		op_rmw = 2'd2,
		op_cond_rmw = 2'd3
	} access_op_t;

	// states of the sequencer that stands in for the CPU timing states
	// st_gap only appears between the read and the write of an atomic pair
	typedef enum logic [2:0] {
		st_idle = 3'd0,
		st_request = 3'd1,
		st_wait = 3'd2,
		st_release = 3'd3,
		st_gap = 3'd4
	} seq_state_t;

	// cycles the bus may stay silent with a pending request before the alarm fires
	localparam int default_alarm_dly_ticks = 8;

	// width of the alarm pulse in cycles
	localparam int default_alarm_ticks = 4;

	// true for the opcodes that do a read and then a write in one bus claim
	// the conditional one may still drop its write after the read
	function automatic logic is_atomic(access_op_t op);
		return (op == op_rmw) || (op == op_cond_rmw);
	endfunction

endpackage

// ==== rtl/cpu_if_top.sv ====
`timescale 1ns/1ns

// CPU side of the bus handshake
// the sequencer drives the interface control, which talks to the bus through zg, ren and rok
module cpu_if_top #(
	parameter int alarm_dly_ticks = cpu_if_pkg::default_alarm_dly_ticks,
	parameter int alarm_ticks = cpu_if_pkg::default_alarm_ticks
) (
	input logic __clk,
	input logic reset,
	input logic start,
	input logic skip_write,
	input logic ren,
	input logic rok,
	input cpu_if_pkg::access_op_t op,
	output logic zg,
	output logic zwzg,
	output logic ok,
	output logic talarm,
	output logic busy,
	output logic done,
	output logic write_phase,
	output cpu_if_pkg::seq_state_t state
);

	// strobes and levels from the sequencer into the interface control
	logic zgi_set;
	logic gotst1;
	logic zgi_j;
	logic ifhold_j;
	logic ifhold_reset;
	logic zw;

	if_sequencer u_if_sequencer (
		.__clk(__clk),
		.reset(reset),
		.start(start),
		.skip_write(skip_write),
		.ok(ok),
		.op(op),
		.zgi_set(zgi_set),
		.gotst1(gotst1),
		.zgi_j(zgi_j),
		.ifhold_j(ifhold_j),
		.ifhold_reset(ifhold_reset),
		.zw(zw),
		.busy(busy),
		.done(done),
		.write_phase(write_phase),
		.state(state)
	);

	// the alarm timing is handed down to the timer inside ifctl
	ifctl #(
		.alarm_dly_ticks(alarm_dly_ticks),
		.alarm_ticks(alarm_ticks)
	) u_ifctl (
		.__clk(__clk),
		.reset(reset),
		.gotst1(gotst1),
		.zgi_j(zgi_j),
		.zgi_set(zgi_set),
		.ifhold_j(ifhold_j),
		.ifhold_reset(ifhold_reset),
		.zw(zw),
		.ren(ren),
		.rok(rok),
		.ok(ok),
		.zg(zg),
		.zwzg(zwzg),
		.talarm(talarm)
	);

endmodule

// ==== rtl/if_sequencer.sv ====
`timescale 1ns/1ns

// small FSM that plays the part of the CPU timing states around a bus access
// one start pulse with an opcode becomes the strobes and levels that ifctl expects
module if_sequencer (
	input logic __clk,
	input logic reset,
	input logic start,
	input logic skip_write,
	input logic ok,
	input cpu_if_pkg::access_op_t op,
	output logic zgi_set,
	output logic gotst1,
	output logic zgi_j,
	output logic ifhold_j,
	output logic ifhold_reset,
	output logic zw,
	output logic busy,
	output logic done,
	output logic write_phase,
	output cpu_if_pkg::seq_state_t state
);

	cpu_if_pkg::seq_state_t state_next;

	// opcode captured at start so the caller may change op while we run
	cpu_if_pkg::access_op_t op_q;

	// set once the read half of an atomic pair is over and the write is running
	logic write_half;

	// the last cycle of release, when ok has just dropped
	logic release_end;

	// we are in the read half of a read-modify-write
	logic atomic_read;

	// the conditional rmw asks to skip its write
	logic skip_now;

	// the current access is followed by the write of the pair
	logic to_write;

	assign release_end = (state == cpu_if_pkg::st_release) && !ok;
	assign atomic_read = cpu_if_pkg::is_atomic(op_q) && !write_half;
	assign skip_now = (op_q == cpu_if_pkg::op_cond_rmw) && skip_write;
	assign to_write = atomic_read && !skip_now;

	// next state logic
	always_comb begin
		state_next = state;
		case (state)
			cpu_if_pkg::st_idle: begin
				// a start while busy never gets here, so it is simply dropped
				if (start)
					state_next = cpu_if_pkg::st_request;
			end
			cpu_if_pkg::st_request: begin
				state_next = cpu_if_pkg::st_wait;
			end
			cpu_if_pkg::st_wait: begin
				// a slow bus just keeps us here longer
				if (ok)
					state_next = cpu_if_pkg::st_release;
			end
			cpu_if_pkg::st_release: begin
				// ok falls once the request register has been cleared by gotst1
				if (!ok)
					state_next = to_write ? cpu_if_pkg::st_gap : cpu_if_pkg::st_idle;
			end
			cpu_if_pkg::st_gap: begin
				// the new request is raised here, ifhold keeps the bus claimed meanwhile
				state_next = cpu_if_pkg::st_wait;
			end
			default: begin
				state_next = cpu_if_pkg::st_idle;
			end
		endcase
	end

	always_ff @(posedge __clk) begin
		if (reset) begin
			state <= cpu_if_pkg::st_idle;
			op_q <= cpu_if_pkg::op_read;
			write_half <= 1'b0;
			gotst1 <= 1'b0;
		end else begin
			state <= state_next;
			// gotst1 comes one cycle after ok is seen, as a single strobe
			gotst1 <= (state == cpu_if_pkg::st_wait) && ok;
			if ((state == cpu_if_pkg::st_idle) && start) begin
				op_q <= op;
				write_half <= 1'b0;
			end else if (release_end && to_write) begin
				write_half <= 1'b1;
			end
		end
	end

	// the request is begun in request and again in gap for the write of a pair
	assign zgi_set = (state == cpu_if_pkg::st_request) || (state == cpu_if_pkg::st_gap);

	// gotst1 only arrives in release, where the toggle clears the set request register
	assign zgi_j = (state == cpu_if_pkg::st_release);

	// hold the interface through the read half of an atomic pair
	assign ifhold_j = busy && atomic_read;

	// a conditional rmw that skips its write gives the bus back right after the read
	assign ifhold_reset = release_end && atomic_read && skip_now;

	// the CPU wants the interface for as long as an operation is running
	assign zw = (state != cpu_if_pkg::st_idle);

	assign busy = (state != cpu_if_pkg::st_idle);

	// done marks the end of the last access of the operation
	assign done = release_end && !to_write;

	// a write-only access or the second half of a pair
	assign write_phase = busy && ((op_q == cpu_if_pkg::op_write) || write_half);

endmodule

// ==== rtl/ifctl.sv ====
`timescale 1ns/1ns

// interface control of the CPU
// keeps the bus request, the atomic hold and the end-of-access flag ok
module ifctl #(
	parameter int alarm_dly_ticks = cpu_if_pkg::default_alarm_dly_ticks,
	parameter int alarm_ticks = cpu_if_pkg::default_alarm_ticks
) (
	input logic __clk,
	input logic reset,
	input logic gotst1,
	input logic zgi_j,
	input logic zgi_set,
	input logic ifhold_j,
	input logic ifhold_reset,
	input logic zw,
	input logic ren,
	input logic rok,
	output logic ok,
	output logic zg,
	output logic zwzg,
	output logic talarm
);

	logic zgi;
	logic ifhold;

	// any answer from the bus, or our own alarm, ends the access
	logic resp;
	logic resp_q;
	logic resp_fall;

	// zwzg as it was in the previous cycle, this is what ok samples
	logic zwzg_q;

	logic ok_q;
	logic ok_rise;

	// request pending with no end of access yet
	logic alarm;

	assign resp = ren | rok | talarm;
	assign resp_fall = resp_q & ~resp;
	assign ok_rise = ok & ~ok_q;

	always_ff @(posedge __clk) begin
		if (reset) begin
			resp_q <= 1'b0;
			zwzg_q <= 1'b0;
			ok_q <= 1'b0;
		end else begin
			resp_q <= resp;
			zwzg_q <= zwzg;
			ok_q <= ok;
		end
	end

	// request register
	// gotst1 wins over zgi_set, with zgi_j high it toggles and otherwise clears
	always_ff @(posedge __clk) begin
		if (reset)
			zgi <= 1'b0;
		else if (gotst1)
			zgi <= zgi_j ? ~zgi : 1'b0;
		else if (zgi_set)
			zgi <= 1'b1;
	end

	// end of access is latched when the answer goes away while we were asking
	// it is released the cycle after the request register has dropped
	always_ff @(posedge __clk) begin
		if (reset)
			ok <= 1'b0;
		else if (!zgi)
			ok <= 1'b0;
		else if (resp_fall && zwzg_q)
			ok <= 1'b1;
	end

	// hold register for read-modify-write
	// it works as a JK stage with k tied to its own output, clocked when ok rises
	// this sets it before zgi drops, so zg stays up between the read and the write
	always_ff @(posedge __clk) begin
		if (reset || ifhold_reset)
			ifhold <= 1'b0;
		else if (ok_rise)
			ifhold <= ifhold_j & ~ifhold;
	end

	assign zwzg = zgi & zw;

	// zg stays up while the answer is still high, and across an atomic pair
	assign zg = zgi | ifhold | (zw & resp);

	assign alarm = zwzg & ~ok;

	alarm_timer #(
		.dly_ticks(alarm_dly_ticks),
		.pulse_ticks(alarm_ticks)
	) u_alarm_timer (
		.__clk(__clk),
		.reset(reset),
		.trigger(alarm),
		.pulse(talarm)
	);

endmodule
